// ==== verilog/uart_bank_macros.svh ====
/*
 * uart bank parameters
 * channel count, data and divider widths, overrun counter width
 * and the baud divider loaded at reset
 */
`ifndef UART_BANK_MACROS_SVH
`define UART_BANK_MACROS_SVH

// number of transmitter channels in the bank
`define UART_CHANNELS 4

// bits per serial character
`define UART_DATA_W 8

// clock cycles per serial bit, register width
`define UART_DIV_W 16

// width of the saturating overrun counter
`define UART_CNT_W 8

// divider value right after reset, kept small for fast simulation
`define UART_DIV_RESET 4

`endif

// ==== verilog/uart_bank_pkg.sv ====
/*
 * uart bank types
 * vector typedefs, host write and start structs, and the
 * transmitter state encoding
 */
`include "uart_bank_macros.svh"

package uart_bank_pkg;

  // one serial data byte
  typedef logic [`UART_DATA_W-1:0] byte_t;

  // clock cycles per serial bit
  typedef logic [`UART_DIV_W-1:0] baud_div_t;

  // one bit per channel
  typedef logic [`UART_CHANNELS-1:0] chan_mask_t;

  // overrun count, saturates at all ones
  typedef logic [`UART_CNT_W-1:0] ovr_cnt_t;

  // host write, addr 0..3 picks a channel, addr 4 the divider
  // channel writes only use the low byte of data
  typedef struct packed {
    logic [2:0] addr;
    baud_div_t  data;
  } host_wr_t;

  // shared start payload, same copy goes to every channel
  typedef struct packed {
    byte_t     data;
    baud_div_t div;
  } tx_start_t;

  // transmitter frame sequence
  typedef enum logic [1:0] {
    IDLE,
    START,
    DATA,
    STOP
  } tx_state_e;

endpackage

// ==== verilog/uart_cmd_decoder.sv ====
/*
 * uart command decoder
 * turns host write strobes into one-hot channel start strobes,
 * holds the shared baud divider and drops writes to busy channels
 */
`timescale 1ns/1ps
`include "uart_bank_macros.svh"

module uart_cmd_decoder (
  input  logic                      clk,
  input  logic                      i_reset,
  input  logic                      i_wr_valid,
  input  uart_bank_pkg::host_wr_t   i_wr,
  input  uart_bank_pkg::chan_mask_t i_busy,
  output uart_bank_pkg::chan_mask_t o_start,
  output uart_bank_pkg::tx_start_t  o_tx,
  output logic                      o_drop
);
  import uart_bank_pkg::*;

  // divider sits right above the channel addresses
  localparam logic [2:0] DIV_ADDR = 3'(`UART_CHANNELS);
  // a bit shorter than two cycles cannot be sampled mid-bit
  localparam baud_div_t  DIV_MIN  = baud_div_t'(2);

  baud_div_t  div_q;
  chan_mask_t sel;
  logic       chan_wr;
  logic       div_wr;
  logic       chan_free;

  // address decode, addresses above DIV_ADDR fall through
  always_comb begin
    chan_wr = i_wr_valid && (i_wr.addr < DIV_ADDR);
    div_wr  = i_wr_valid && (i_wr.addr == DIV_ADDR);
    // one-hot select of the addressed channel
    sel = '0;
    if (chan_wr) begin
      sel = chan_mask_t'(1) << i_wr.addr;
    end
    // a pending strobe counts as busy, the channel has not seen it yet
    chan_free = ((sel & (i_busy | o_start)) == '0);
  end

  // control path, strobes last one cycle
  always_ff @(posedge clk) begin
    if (i_reset) begin
      div_q   <= baud_div_t'(`UART_DIV_RESET);
      o_start <= '0;
      o_drop  <= 1'b0;
    end else begin
      o_start <= '0;
      o_drop  <= 1'b0;
      // floor the divider at DIV_MIN
      if (div_wr) begin
        div_q <= (i_wr.data < DIV_MIN) ? DIV_MIN : i_wr.data;
      end
      if (chan_wr) begin
        if (chan_free) begin
          o_start <= sel;
        end else begin
          // collector counts this as an overrun
          o_drop <= 1'b1;
        end
      end
    end
  end

  // start payload, only loaded for an accepted channel write
  // carries the divider as it stands now, later writes do not touch it
  always_ff @(posedge clk) begin
    if (chan_wr && chan_free) begin
      o_tx.data <= i_wr.data[`UART_DATA_W-1:0];
      o_tx.div  <= div_q;
    end
  end

endmodule

// ==== verilog/uart_tx_channel.sv ====
/*
 * uart transmit channel
 * one 8N1 transmitter, start bit low, data LSB first, stop bit high,
 * each bit held for the divider latched at start
 */
`timescale 1ns/1ps
`include "uart_bank_macros.svh"

module uart_tx_channel (
  input  logic                     clk,
  input  logic                     i_reset,
  input  logic                     i_start,
  input  uart_bank_pkg::tx_start_t i_tx,
  output logic                     o_txd,
  output logic                     o_busy,
  output logic                     o_done
);
  import uart_bank_pkg::*;

  localparam int BIT_W = $clog2(`UART_DATA_W);
  // index of the last data bit
  localparam logic [BIT_W-1:0] LAST_BIT = BIT_W'(`UART_DATA_W - 1);

  tx_state_e        state;
  byte_t            shift_q;
  baud_div_t        div_q;
  baud_div_t        baud_cnt;
  logic [BIT_W-1:0] bit_cnt;
  logic             bit_end;

  // last cycle of the current serial bit
  assign bit_end = (baud_cnt == div_q - 1'b1);

  // frame sequencing and counters
  always_ff @(posedge clk) begin
    if (i_reset) begin
      state    <= IDLE;
      baud_cnt <= '0;
      bit_cnt  <= '0;
    end else begin
      case (state)
        IDLE: begin
          baud_cnt <= '0;
          bit_cnt  <= '0;
          // start bit goes out on the next cycle
          if (i_start) begin
            state <= START;
          end
        end
        START, DATA, STOP: begin
          if (bit_end) begin
            baud_cnt <= '0;
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
          if (bit_end) begin
            case (state)
              START: begin
                state   <= DATA;
                bit_cnt <= '0;
              end
              DATA: begin
                // eight data bits then the stop bit
                if (bit_cnt == LAST_BIT) begin
                  state <= STOP;
                end else begin
                  bit_cnt <= bit_cnt + 1'b1;
                end
              end
              default: begin
                // end of stop bit, back to idle
                state <= IDLE;
              end
            endcase
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // byte and divider are captured once per frame
  always_ff @(posedge clk) begin
    if ((state == IDLE) && i_start) begin
      shift_q <= i_tx.data;
      div_q   <= i_tx.div;
    end else if ((state == DATA) && bit_end) begin
      // next data bit moves into bit 0
      shift_q <= shift_q >> 1;
    end
  end

  // line level follows the state, idle line stays high
  always_comb begin
    case (state)
      START:   o_txd = 1'b0;
      DATA:    o_txd = shift_q[0];
      default: o_txd = 1'b1;
    endcase
  end

  assign o_busy = (state != IDLE);
  // strobe in the very last busy cycle
  assign o_done = (state == STOP) && bit_end;

endmodule

// ==== verilog/uart_status_collector.sv ====
/*
 * uart status collector
 * sticky per-channel done flags, interrupt line and a
 * saturating count of dropped writes
 */
`timescale 1ns/1ps

module uart_status_collector (
  input  logic                      clk,
  input  logic                      i_reset,
  input  uart_bank_pkg::chan_mask_t i_done,
  input  logic                      i_drop,
  input  logic                      i_status_clear,
  output uart_bank_pkg::chan_mask_t o_done_flags,
  output logic                      o_irq,
  output uart_bank_pkg::ovr_cnt_t   o_overruns
);
  import uart_bank_pkg::*;

  chan_mask_t flags_nxt;
  logic       cnt_full;

  // next flag value, a done strobe beats a clear for its own bit
  always_comb begin
    if (i_status_clear) begin
      flags_nxt = i_done;
    end else begin
      flags_nxt = o_done_flags | i_done;
    end
  end

  // counter holds at all ones
  assign cnt_full = (o_overruns == '1);

  // flags and irq update together, irq stays in step with the flags
  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_done_flags <= '0;
      o_irq        <= 1'b0;
    end else begin
      o_done_flags <= flags_nxt;
      o_irq        <= |flags_nxt;
    end
  end

  // overrun count
  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_overruns <= '0;
    end else if (i_status_clear) begin
      // clear also discards a drop in the same cycle
      o_overruns <= '0;
    end else if (i_drop && !cnt_full) begin
      o_overruns <= o_overruns + 1'b1;
    end
  end

endmodule

// ==== verilog/uart_bank_top.sv ====
/*
 * uart bank top
 * command decoder, a row of identical 8N1 transmitters
 * and the status collector
 */
`timescale 1ns/1ps
`include "uart_bank_macros.svh"

module uart_bank_top (
  input  logic                      clk,
  input  logic                      i_reset,
  input  logic                      i_wr_valid,
  input  uart_bank_pkg::host_wr_t   i_wr,
  input  logic                      i_status_clear,
  output uart_bank_pkg::chan_mask_t o_txd,
  output uart_bank_pkg::chan_mask_t o_busy,
  output uart_bank_pkg::chan_mask_t o_done_flags,
  output logic                      o_irq,
  output uart_bank_pkg::ovr_cnt_t   o_overruns
);
  import uart_bank_pkg::*;

  // decoder to channels
  chan_mask_t start_mask;
  tx_start_t  tx_start;
  // channels to collector
  chan_mask_t done_mask;
  // decoder to collector
  logic       drop;

  uart_cmd_decoder u_decoder (
    .clk        (clk),
    .i_reset    (i_reset),
    .i_wr_valid (i_wr_valid),
    .i_wr       (i_wr),
    .i_busy     (o_busy),
    .o_start    (start_mask),
    .o_tx       (tx_start),
    .o_drop     (drop)
  );

  // one transmitter per channel, all share the start payload
  for (genvar g = 0; g < `UART_CHANNELS; g++) begin : g_chan
    uart_tx_channel u_chan (
      .clk     (clk),
      .i_reset (i_reset),
      .i_start (start_mask[g]),
      .i_tx    (tx_start),
      .o_txd   (o_txd[g]),
      .o_busy  (o_busy[g]),
      .o_done  (done_mask[g])
    );
  end

  uart_status_collector u_status (
    .clk            (clk),
    .i_reset        (i_reset),
    .i_done         (done_mask),
    .i_drop         (drop),
    .i_status_clear (i_status_clear),
    .o_done_flags   (o_done_flags),
    .o_irq          (o_irq),
    .o_overruns     (o_overruns)
  );

endmodule

// ==== tests/uart_bank_assertions.sv ====
/*
 * uart channel assertions
 * serial framing and start and done strobe rules,
 * bound into every transmit channel
 */
`timescale 1ns/1ps

module uart_bank_assertions (
  input logic                     clk,
  input logic                     i_reset,
  input logic                     i_start,
  input uart_bank_pkg::tx_state_e state,
  input logic                     o_txd,
  input logic                     o_busy,
  input logic                     o_done
);
  import uart_bank_pkg::*;

  // a start strobe into an idle channel opens the frame with a low line
  start_bit_low: assert property (@(posedge clk) disable iff (i_reset)
    (i_start && !o_busy) |=> ((state == START) && !o_txd))
    else $error("start bit is not low");

  // the frame only ends out of a high stop bit
  stop_bit_high: assert property (@(posedge clk) disable iff (i_reset)
    $fell(o_busy) |-> $past((state == STOP) && o_txd))
    else $error("stop bit is not high");

  // done is one cycle, the last busy one
  done_at_end: assert property (@(posedge clk) disable iff (i_reset)
    $fell(o_busy) |-> $past(o_done)) else $error("busy ended without done");
  done_last: assert property (@(posedge clk) disable iff (i_reset)
    o_done |=> (!o_done && !o_busy)) else $error("done not at end of busy");

  // idle line stays high until a start strobe arrives
  idle_high: assert property (@(posedge clk) disable iff (i_reset)
    (!o_busy && !i_start) |=> o_txd) else $error("line low while idle");

  // start strobe only to an idle channel, never twice in a row
  start_idle: assert property (@(posedge clk) disable iff (i_reset)
    i_start |-> !o_busy ##1 !i_start) else $error("start strobe while busy");

endmodule

bind uart_tx_channel uart_bank_assertions u_assert (
  .clk     (clk),
  .i_reset (i_reset),
  .i_start (i_start),
  .state   (state),
  .o_txd   (o_txd),
  .o_busy  (o_busy),
  .o_done  (o_done)
);

// ==== tests/uart_bank_tb.sv ====
/*
 * uart bank testbench
 * random host writes from an LFSR, a cycle model of the bank,
 * one serial receiver per channel and a closing report
 */
`timescale 1ns/1ps
`include "uart_bank_macros.svh"

module uart_bank_tb;
  import uart_bank_pkg::*;

  localparam int NCH         = `UART_CHANNELS;
  localparam int NUM_WRITES  = 300;
  localparam int BURST_LEN   = 280;
  // 300 writes with up to 10 x 6 cycles of frame each, plus the burst and margin
  localparam int CYCLE_LIMIT = 20000;
  localparam int EXP_DEPTH   = 1024;

  logic       clk = 1'b0;
  logic       i_reset;
  logic       i_wr_valid;
  host_wr_t   i_wr;
  logic       i_status_clear;
  chan_mask_t o_txd;
  chan_mask_t o_busy;
  chan_mask_t o_done_flags;
  logic       o_irq;
  ovr_cnt_t   o_overruns;

  logic [15:0] lfsr = 16'd42;
  int errors = 0;
  int checks = 0;
  int cycles = 0;

  // model state, as it stands just after a clock edge
  int         m_div;
  int         m_left [NCH];
  int         m_pend_div [NCH];
  chan_mask_t m_pend;
  chan_mask_t m_flags;
  logic       m_irq;
  logic       m_drop;
  int         m_ovr;

  // accepted bytes per channel, with the divider of each frame
  byte_t exp_data [NCH][EXP_DEPTH];
  int    exp_div [NCH][EXP_DEPTH];
  int    wr_ptr [NCH];
  int    rd_ptr [NCH];

  uart_bank_top UUT (
    .clk            (clk),
    .i_reset        (i_reset),
    .i_wr_valid     (i_wr_valid),
    .i_wr           (i_wr),
    .i_status_clear (i_status_clear),
    .o_txd          (o_txd),
    .o_busy         (o_busy),
    .o_done_flags   (o_done_flags),
    .o_irq          (o_irq),
    .o_overruns     (o_overruns)
  );

  // 40 ns period
  always #20 clk = ~clk;

  // galois lfsr, one step per bit taken
  function automatic int take_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | lfsr[0];
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
    end
    return v;
  endfunction

  task automatic check_eq(input int got, input int exp, input string what);
    checks++;
    assert (got == exp) else begin
      errors++;
      $display("error at %0t: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  // one clock edge of the bank, inputs are those applied before the edge
  task automatic model_step;
    chan_mask_t done_pre;
    chan_mask_t busy_pre;
    chan_mask_t pend_pre;
    int         c;
    pend_pre = m_pend;
    for (int i = 0; i < NCH; i++) begin
      done_pre[i] = (m_left[i] == 1);
      busy_pre[i] = (m_left[i] > 0);
    end
    // collector, a done strobe survives a clear in the same cycle
    m_flags = i_status_clear ? done_pre : (m_flags | done_pre);
    m_irq   = |m_flags;
    if (i_status_clear) begin
      m_ovr = 0;
    end else if (m_drop && m_ovr < 255) begin
      m_ovr++;
    end
    // channels, busy for 10 bits after the strobe cycle
    for (int i = 0; i < NCH; i++) begin
      if (pend_pre[i]) begin
        m_left[i] = 10 * m_pend_div[i];
      end else if (m_left[i] > 0) begin
        m_left[i]--;
      end
    end
    // decoder sees busy and pending as they were before the edge
    m_pend = '0;
    m_drop = 1'b0;
    if (i_wr_valid && i_wr.addr < NCH) begin
      c = int'(i_wr.addr);
      if (busy_pre[c] || pend_pre[c]) begin
        m_drop = 1'b1;
      end else begin
        m_pend[c]     = 1'b1;
        m_pend_div[c] = m_div;
        exp_data[c][wr_ptr[c]] = i_wr.data[7:0];
        exp_div[c][wr_ptr[c]]  = m_div;
        wr_ptr[c]++;
      end
    end else if (i_wr_valid && i_wr.addr == NCH) begin
      m_div = (i_wr.data < 2) ? 2 : int'(i_wr.data);
    end
  endtask

  task automatic check_outputs;
    chan_mask_t busy_exp;
    for (int c = 0; c < NCH; c++) begin
      busy_exp[c] = (m_left[c] > 0);
      // line stays high outside a frame
      if (m_left[c] == 0) begin
        check_eq(o_txd[c], 1, "idle line level");
      end
    end
    check_eq(o_busy, busy_exp, "busy mask");
    check_eq(o_done_flags, m_flags, "done flags");
    check_eq(o_irq, m_irq, "irq");
    check_eq(o_overruns, m_ovr, "overrun count");
  endtask

  // edge, model update, then compare once the outputs have settled
  task automatic run_cycle;
    @(posedge clk);
    model_step;
    #1;
    check_outputs;
  endtask

  function automatic logic model_active();
    logic act;
    act = (m_pend != '0) || m_drop;
    for (int c = 0; c < NCH; c++) begin
      if (m_left[c] > 0) begin
        act = 1'b1;
      end
    end
    return act;
  endfunction

  // one receiver per line, sampling mid-bit at the frame's divider
  for (genvar g = 0; g < NCH; g++) begin : g_rx
    initial begin : rx_loop
      int         div;
      int         elapsed;
      logic [9:0] bits;
      @(negedge i_reset);
      forever begin
        @(negedge o_txd[g]);
        assert (rd_ptr[g] < wr_ptr[g]) else begin
          errors++;
          $display("channel %0d sent a frame that was never accepted, at %0t", g, $time);
        end
        if (rd_ptr[g] < wr_ptr[g]) begin
          div = exp_div[g][rd_ptr[g]];
          elapsed = 0;
          for (int b = 0; b < 10; b++) begin
            // cycles counted from the first cycle of the start bit
            while (elapsed < b * div + div / 2) begin
              @(posedge clk);
              elapsed++;
            end
            #1;
            bits[b] = o_txd[g];
          end
          check_eq(bits[0], 0, "start bit");
          check_eq(bits[9], 1, "stop bit");
          check_eq(bits[8:1], exp_data[g][rd_ptr[g]], "received byte");
          rd_ptr[g]++;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("checks %0d, errors %0d", checks, errors);
      $display("=== FAIL ===");
      $finish;
    end
  end

  initial begin
    int gap;
    int kind;
    int v;
    i_reset        = 1'b1;
    i_wr_valid     = 1'b0;
    i_wr           = '0;
    i_status_clear = 1'b0;
    m_div   = `UART_DIV_RESET;
    m_pend  = '0;
    m_flags = '0;
    m_irq   = 1'b0;
    m_drop  = 1'b0;
    m_ovr   = 0;
    for (int c = 0; c < NCH; c++) begin
      m_left[c]     = 0;
      m_pend_div[c] = 0;
      wr_ptr[c]     = 0;
      rd_ptr[c]     = 0;
    end
    repeat (2) @(posedge clk);
    #1;
    i_reset = 1'b0;
    // state straight after reset
    check_outputs;
    for (int n = 0; n < NUM_WRITES; n++) begin
      gap = take_bits(4);
      repeat (gap) begin
        i_status_clear = (take_bits(5) == 0);
        run_cycle;
      end
      kind = take_bits(5);
      i_wr_valid = 1'b1;
      if (kind < 2) begin
        // divider 0..6, anything below 2 acts as 2
        v = take_bits(3);
        i_wr.addr = 3'(NCH);
        i_wr.data = baud_div_t'((v > 6) ? 6 : v);
      end else if (kind < 4) begin
        // unmapped addresses 5..7
        v = take_bits(2);
        i_wr.addr = 3'(5 + (v % 3));
        i_wr.data = baud_div_t'(take_bits(16));
      end else begin
        i_wr.addr = 3'(take_bits(2));
        i_wr.data = baud_div_t'(take_bits(8));
      end
      i_status_clear = (take_bits(5) == 0);
      run_cycle;
      i_wr_valid     = 1'b0;
      i_status_clear = 1'b0;
    end
    // clear, then hammer channel 0 until the overrun count saturates
    i_status_clear = 1'b1;
    run_cycle;
    i_status_clear = 1'b0;
    i_wr_valid = 1'b1;
    i_wr.addr  = 3'd0;
    for (int n = 0; n < BURST_LEN; n++) begin
      i_wr.data = baud_div_t'(take_bits(8));
      run_cycle;
    end
    i_wr_valid = 1'b0;
    while (model_active()) begin
      run_cycle;
    end
    repeat (4) run_cycle;
    i_status_clear = 1'b1;
    run_cycle;
    i_status_clear = 1'b0;
    run_cycle;
    for (int c = 0; c < NCH; c++) begin
      check_eq(rd_ptr[c], wr_ptr[c], "frames received");
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+verilog
verilog/uart_bank_pkg.sv
verilog/uart_cmd_decoder.sv
verilog/uart_tx_channel.sv
verilog/uart_status_collector.sv
verilog/uart_bank_top.sv
tests/uart_bank_assertions.sv
tests/uart_bank_tb.sv

// ==== Bender.yml ====
package:
  name: uart_bank

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/uart_bank_pkg.sv
      - verilog/uart_cmd_decoder.sv
      - verilog/uart_tx_channel.sv
      - verilog/uart_status_collector.sv
      - verilog/uart_bank_top.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - tests/uart_bank_assertions.sv
      - tests/uart_bank_tb.sv
